//--- verilog/fetchPkg.sv
package fetchPkg;

    // Program counter and every address in the front end count words,
    // not bytes, so PC plus one is the next instruction
    localparam int ADDR_W = 32;

    // Width of a single instruction word
    localparam int INSTR_W = 32;

    // A cache block holds sixteen instructions
    localparam int WORDS_PER_BLOCK = 16;

    // The memory controller delivers a whole block in one beat
    localparam int BLOCK_W = WORDS_PER_BLOCK * INSTR_W;

    // Low address bits pick the word inside a block
    localparam int OFFSET_W = 4;

    // Each way has eight sets
    localparam int NUM_SETS = 8;

    // Bits above the offset select the set
    localparam int INDEX_W = 3;

    // Whatever is left above index and offset is stored as the tag
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    // Four ways give a four-way set-associative cache
    localparam int NUM_WAYS = 4;

    // Enough bits to name any single way
    localparam int WAY_W = 2;

    // First fetch address after reset
    localparam logic [ADDR_W-1:0] RESET_PC = '0;

endpackage

//--- verilog/cacheLookupIf.sv
`timescale 1ns/1ps

// Lookup and refill bundle from the fetch stage to every cache way
interface cacheLookupIf;

    import fetchPkg::*;

    // Current PC split into its cache fields
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;

    // Single-cycle write strobe, high only when the FSM accepts a block
    logic refill;

    // Block returned by the memory controller
    logic [BLOCK_W-1:0] refillBlock;

    // Way that takes the block, chosen by the set's round-robin pointer
    logic [WAY_W-1:0] victimWay;

    // The fetch stage owns all of the fields
    modport fetch (
        output tag,
        output index,
        output offset,
        output refill,
        output refillBlock,
        output victimWay
    );

    // Ways only look at them
    modport way (
        input tag,
        input index,
        input offset,
        input refill,
        input refillBlock,
        input victimWay
    );

endinterface

//--- verilog/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic                         clk,
    input  logic                         rst,
    // Freezes the PC while high
    input  logic                         halt,
    // Memory stage has a DMA transfer in flight
    input  logic                         stallDMAMem,
    // Decode stage asks to hold the current instruction
    input  logic                         blockInstruction,
    // Strobe from the memory controller that mcDataIn holds a block
    input  logic                         mcDataValid,
    input  logic [fetchPkg::ADDR_W-1:0]  nextPC,
    input  logic [fetchPkg::BLOCK_W-1:0] mcDataIn,
    // Miss status coming back from the way merge
    input  logic                         cacheMiss,
    output logic [fetchPkg::ADDR_W-1:0]  pcPlus1,
    output logic [fetchPkg::ADDR_W-1:0]  missAddr,
    cacheLookupIf.fetch                  lookup
);

    import fetchPkg::*;

    // IDLE waits for a miss, REQUEST waits for the refill strobe
    typedef enum logic {
        IDLE    = 1'b0,
        REQUEST = 1'b1
    } missStateT;

    missStateT currState;
    missStateT nextState;

    logic [ADDR_W-1:0] currPC;
    logic              stallPC;
    logic              refillNow;

    // One round-robin victim pointer per set
    logic [WAY_W-1:0] victimPtr [NUM_SETS];

    // Any stall source or a miss keeps the PC where it is
    assign stallPC = halt | stallDMAMem | blockInstruction | cacheMiss;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            currPC <= RESET_PC;
        end else if (!stallPC) begin
            currPC <= nextPC;
        end
    end

    // Sequential successor, addresses are word addresses so the step is one
    assign pcPlus1 = currPC + ADDR_W'(1);

    // Controller fetches whole blocks, so the offset bits are cleared
    assign missAddr = {currPC[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // Split the PC into the fields every way needs
    assign lookup.offset = currPC[OFFSET_W-1:0];
    assign lookup.index  = currPC[OFFSET_W +: INDEX_W];
    assign lookup.tag    = currPC[ADDR_W-1 -: TAG_W];

    // A strobe counts only while a request is outstanding
    // Strobes that show up in IDLE are dropped here
    assign refillNow = (currState == REQUEST) && mcDataValid;

    assign lookup.refill      = refillNow;
    assign lookup.refillBlock = mcDataIn;
    assign lookup.victimWay   = victimPtr[lookup.index];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            currState <= IDLE;
        end else begin
            currState <= nextState;
        end
    end

    always_comb begin
        nextState = currState;
        case (currState)
            IDLE: begin
                // A miss seen now turns into a request on the next edge
                if (cacheMiss) begin
                    nextState = REQUEST;
                end
            end
            REQUEST: begin
                // The block is written on this same edge
                if (mcDataValid) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    // The pointer of the refilled set moves on to the next way
    // and wraps around after the last one
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                victimPtr[s] <= '0;
            end
        end else if (refillNow) begin
            victimPtr[lookup.index] <= victimPtr[lookup.index] + WAY_W'(1);
        end
    end

endmodule

//--- verilog/icacheWay.sv
`timescale 1ns/1ps

module icacheWay #(
    // Number of this way, compared with victimWay on refill
    parameter int WAY_ID = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    cacheLookupIf.way                    lookup,
    output logic                         hit,
    output logic [fetchPkg::INSTR_W-1:0] word
);

    import fetchPkg::*;

    // Valid bit per set, cleared by reset so the cache starts empty
    logic [NUM_SETS-1:0] validBits;

    // Tag and block storage per set
    logic [TAG_W-1:0]   tagMem   [NUM_SETS];
    logic [BLOCK_W-1:0] blockMem [NUM_SETS];

    // Block of the indexed set viewed as an array of words
    logic [WORDS_PER_BLOCK-1:0][INSTR_W-1:0] setWords;

    logic selected;

    // This way takes the block only when the victim pointer names it
    assign selected = lookup.refill && (lookup.victimWay == WAY_W'(WAY_ID));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            validBits <= '0;
        end else if (selected) begin
            validBits[lookup.index] <= 1'b1;
        end
    end

    // Data and tag written with the valid bit
    always_ff @(posedge clk) begin
        if (selected) begin
            tagMem[lookup.index]   <= lookup.tag;
            blockMem[lookup.index] <= lookup.refillBlock;
        end
    end

    // Tag compare against the indexed set
    assign hit = validBits[lookup.index] && (tagMem[lookup.index] == lookup.tag);

    // Word zero sits in the low bits of the block
    assign setWords = blockMem[lookup.index];

    // Offset picks the instruction, whether or not the way hits
    // The merge masks the word of a way that misses
    assign word = setWords[lookup.offset];

endmodule

//--- verilog/wayMerge.sv
`timescale 1ns/1ps

module wayMerge (
    // One hit flag per way
    input  logic [fetchPkg::NUM_WAYS-1:0]                        wayHit,
    // Offset-selected word of each way
    input  logic [fetchPkg::NUM_WAYS-1:0][fetchPkg::INSTR_W-1:0] wayWord,
    output logic [fetchPkg::INSTR_W-1:0]                         instr,
    output logic                                                 cacheHit,
    output logic                                                 cacheMiss
);

    import fetchPkg::*;

    // And-or mux over the ways
    // A block lives in at most one way, since it is only loaded after a miss,
    // so at most one term is nonzero
    always_comb begin
        instr = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            instr = instr | ({INSTR_W{wayHit[w]}} & wayWord[w]);
        end
    end

    // Any matching way is a hit, no way means zero on instr and a miss
    assign cacheHit  = |wayHit;
    assign cacheMiss = ~cacheHit;

endmodule

//--- verilog/fetchTop.sv
`timescale 1ns/1ps

module fetchTop (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         halt,
    input  logic [fetchPkg::ADDR_W-1:0]  nextPC,
    input  logic                         stallDMAMem,
    input  logic                         blockInstruction,
    input  logic                         mcDataValid,
    input  logic [fetchPkg::BLOCK_W-1:0] mcDataIn,
    output logic [fetchPkg::INSTR_W-1:0] instr,
    output logic [fetchPkg::ADDR_W-1:0]  pcPlus1,
    output logic                         cacheMiss,
    output logic [fetchPkg::ADDR_W-1:0]  missAddr
);

    import fetchPkg::*;

    // Shared lookup bus from the fetch stage into all ways
    cacheLookupIf lookupBus ();

    // Per-way results gathered for the merge
    logic [NUM_WAYS-1:0]              wayHit;
    logic [NUM_WAYS-1:0][INSTR_W-1:0] wayWord;

    fetchStage iFetch (
        .clk              (clk),
        .rst              (rst),
        .halt             (halt),
        .stallDMAMem      (stallDMAMem),
        .blockInstruction (blockInstruction),
        .mcDataValid      (mcDataValid),
        .nextPC           (nextPC),
        .mcDataIn         (mcDataIn),
        .cacheMiss        (cacheMiss),
        .pcPlus1          (pcPlus1),
        .missAddr         (missAddr),
        .lookup           (lookupBus.fetch)
    );

    // Identical ways, each one knows its own number
    for (genvar g = 0; g < NUM_WAYS; g++) begin : genWay
        icacheWay #(
            .WAY_ID (g)
        ) iWay (
            .clk    (clk),
            .rst    (rst),
            .lookup (lookupBus.way),
            .hit    (wayHit[g]),
            .word   (wayWord[g])
        );
    end

    // Hit status is only needed inverted, as cacheMiss
    wayMerge iMerge (
        .wayHit    (wayHit),
        .wayWord   (wayWord),
        .instr     (instr),
        .cacheHit  (),
        .cacheMiss (cacheMiss)
    );

endmodule

//--- sim/fetchTb.sv
`timescale 1ns/1ps

module fetchTb;

    import fetchPkg::*;

    // DUT inputs
    logic                 clk = 1'b0;
    logic                 rst;
    logic                 halt;
    logic [ADDR_W-1:0]    nextPC;
    logic                 stallDMAMem;
    logic                 blockInstruction;
    logic                 mcDataValid;
    logic [BLOCK_W-1:0]   mcDataIn;

    // DUT outputs
    logic [INSTR_W-1:0]   instr;
    logic [ADDR_W-1:0]    pcPlus1;
    logic                 cacheMiss;
    logic [ADDR_W-1:0]    missAddr;

    // Steps from the pattern file with one entry per step in each queue
    logic [31:0] stepBranch [$];
    logic [31:0] stepTarget [$];
    logic [31:0] stepStall  [$];
    logic [31:0] stepBlock  [$];
    logic [31:0] stepHalt   [$];
    int          numSteps;
    logic        loaded = 1'b0;

    // Reference model of PC, tag store, victim pointers and the miss FSM
    logic [ADDR_W-1:0] mPc;
    logic              mValid [NUM_SETS][NUM_WAYS];
    logic [TAG_W-1:0]  mTag   [NUM_SETS][NUM_WAYS];
    logic [WAY_W-1:0]  mPtr   [NUM_SETS];
    logic              mReq;
    int                waitLeft;
    logic [31:0]       rngState;

    // What the testbench put on the inputs for the coming edge
    logic [ADDR_W-1:0] dNext;
    logic              dStall;
    logic              dBlock;
    logic              dHalt;
    logic              dValid;

    fetchTop i_dut (
        .clk              (clk),
        .rst              (rst),
        .halt             (halt),
        .nextPC           (nextPC),
        .stallDMAMem      (stallDMAMem),
        .blockInstruction (blockInstruction),
        .mcDataValid      (mcDataValid),
        .mcDataIn         (mcDataIn),
        .instr            (instr),
        .pcPlus1          (pcPlus1),
        .cacheMiss        (cacheMiss),
        .missAddr         (missAddr)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // Each word of memory is its address times an odd constant
    function automatic logic [INSTR_W-1:0] instrAt(input logic [ADDR_W-1:0] a);
        return a * 32'h9E37_79B1;
    endfunction

    // Whole block starting at base, optionally inverted for stray strobes
    function automatic logic [BLOCK_W-1:0] blockFor(input logic [ADDR_W-1:0] base,
                                                    input logic invert);
        logic [BLOCK_W-1:0] blk;
        blk = '0;
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            blk[i*INSTR_W +: INSTR_W] = instrAt(base + ADDR_W'(i)) ^ {INSTR_W{invert}};
        end
        return blk;
    endfunction

    // 32-bit xorshift generator
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [INDEX_W-1:0] setOf(input logic [ADDR_W-1:0] a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic logic [TAG_W-1:0] tagOf(input logic [ADDR_W-1:0] a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [ADDR_W-1:0] blockBase(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
    endfunction

    // True when no way of the model holds the block of address a
    function automatic logic modelMisses(input logic [ADDR_W-1:0] a);
        logic [INDEX_W-1:0] idx;
        logic               found;
        idx = setOf(a);
        found = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (mValid[idx][w] && (mTag[idx][w] == tagOf(a))) begin
                found = 1'b1;
            end
        end
        return !found;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic loadPatterns();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f;
        logic [31:0] t;
        logic [31:0] s;
        logic [31:0] b;
        logic [31:0] h;
        fd = $fopen("sim/fetchPatterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file sim/fetchPatterns.txt");
            $display("Simulation FAILED");
            $fatal(1, "missing pattern file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                // Lines starting with a hash mark are comments
                if (cnt > 0 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h", f, t, s, b, h);
                    if (cnt == 5) begin
                        stepBranch.push_back(f);
                        stepTarget.push_back(t);
                        stepStall.push_back(s);
                        stepBlock.push_back(b);
                        stepHalt.push_back(h);
                    end
                end
            end
            $fclose(fd);
            numSteps = stepBranch.size();
            if (numSteps == 0) begin
                $display("The pattern file holds no steps");
                $display("Simulation FAILED");
                $fatal(1, "empty pattern file");
            end
        end
    endtask

    // Put the model in its state after reset and reseed the generator
    task automatic resetModel();
        mPc = RESET_PC;
        mReq = 1'b0;
        waitLeft = 0;
        rngState = 32'd28870;
        for (int s = 0; s < NUM_SETS; s++) begin
            mPtr[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                mValid[s][w] = 1'b0;
                mTag[s][w] = '0;
            end
        end
        dNext = '0;
        dStall = 1'b0;
        dBlock = 1'b0;
        dHalt = 1'b0;
        dValid = 1'b0;
    endtask

    // Apply one rising edge to the model with the inputs driven for it
    // A step is used up on an edge where the lookup did not miss
    task automatic applyEdge(output logic consumed);
        logic               missPre;
        logic [INDEX_W-1:0] idx;
        missPre = modelMisses(mPc);
        idx = setOf(mPc);
        if (mReq) begin
            // The strobe writes the block into the set's victim way
            if (dValid) begin
                mValid[idx][mPtr[idx]] = 1'b1;
                mTag[idx][mPtr[idx]] = tagOf(mPc);
                mPtr[idx] = mPtr[idx] + WAY_W'(1);
                mReq = 1'b0;
            end
        end else if (missPre) begin
            // Controller picks a latency of 1 to 6 cycles for this request
            mReq = 1'b1;
            rngState = xorshift32(rngState);
            waitLeft = 1 + int'(rngState % 32'd6);
        end
        if (!(dHalt || dStall || dBlock || missPre)) begin
            mPc = dNext;
        end
        consumed = !missPre;
    endtask

    task automatic driveStep(input int k);
        dStall = (stepStall[k] != 32'd0);
        dBlock = (stepBlock[k] != 32'd0);
        dHalt = (stepHalt[k] != 32'd0);
        // A branch takes its target and any other step the sequential address
        if (stepBranch[k] != 32'd0) begin
            dNext = stepTarget[k];
        end else begin
            dNext = mPc + ADDR_W'(1);
        end
        nextPC <= dNext;
        stallDMAMem <= dStall;
        blockInstruction <= dBlock;
        halt <= dHalt;
    endtask

    // The memory controller sends one strobe when the latency runs out
    // and now and then a stray strobe with wrong data while idle
    task automatic driveController();
        logic [BLOCK_W-1:0] data;
        if (mReq) begin
            waitLeft = waitLeft - 1;
            dValid = (waitLeft == 0);
            data = blockFor(blockBase(mPc), 1'b0);
        end else begin
            rngState = xorshift32(rngState);
            dValid = (rngState[1:0] == 2'b00);
            data = blockFor(blockBase(mPc), 1'b1);
        end
        mcDataValid <= dValid;
        mcDataIn <= data;
    endtask

    task automatic checkOutputs();
        logic expMiss;
        expMiss = modelMisses(mPc);
        compareValue("missAddr", missAddr, blockBase(mPc));
        compareValue("pcPlus1", pcPlus1, mPc + ADDR_W'(1));
        compareValue("cacheMiss", 32'(cacheMiss), 32'(expMiss));
        if (!expMiss) begin
            compareValue("instr", instr, instrAt(mPc));
        end else begin
            // No way hits, so the merge gives an all-zero word
            compareValue("instr", instr, 32'd0);
        end
    endtask

    initial begin : stimulus
        int   k;
        logic consumed;
        rst <= 1'b1;
        halt <= 1'b0;
        nextPC <= '0;
        stallDMAMem <= 1'b0;
        blockInstruction <= 1'b0;
        mcDataValid <= 1'b0;
        mcDataIn <= '0;
        resetModel();
        loadPatterns();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        k = 0;
        driveStep(k);
        driveController();
        @(negedge clk);
        // The empty cache misses on the reset PC
        compareValue("missAddr", missAddr, RESET_PC);
        compareValue("cacheMiss", 32'(cacheMiss), 32'd1);
        compareValue("pcPlus1", pcPlus1, RESET_PC + ADDR_W'(1));
        while (k < numSteps) begin
            @(posedge clk);
            applyEdge(consumed);
            if (consumed) begin
                k++;
            end
            if (k < numSteps) begin
                driveStep(k);
            end
            driveController();
            // Outputs are settled by the falling edge
            @(negedge clk);
            checkOutputs();
        end
        $display("Simulation PASSED");
        $finish;
    end

    // A step takes at most about nine cycles even with the longest refill
    initial begin : watchdog
        int limitCycles;
        wait (loaded);
        limitCycles = numSteps * 10 + 6;
        #(limitCycles * 100);
        $display("Timeout: the pattern list did not finish within %0d clock cycles",
                 limitCycles);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- sim/fetchPatterns.txt
# Columns: branch flag, branch target (hex word address), stallDMAMem, blockInstruction, halt
# With the flag clear nextPC is pcPlus1 and the target column is unused
0 00000000 0 0 0
0 00000000 0 0 0
0 00000000 1 0 0
0 00000000 0 1 0
0 00000000 0 0 1
0 00000000 1 1 1
0 00000000 0 0 0
1 0000000e 0 0 0
0 00000000 0 0 0
0 00000000 0 0 0
0 00000000 1 0 0
0 00000000 0 0 1
0 00000000 0 0 0
1 00000020 0 0 0
1 000000a0 0 0 0
1 00000120 0 0 0
1 000001a0 0 0 0
1 00000225 0 0 0
0 00000000 0 0 0
1 00000120 0 0 0
1 00000021 0 0 0
1 000001a3 0 0 0
1 000000a7 0 0 0
1 00000120 0 0 0
1 0000022f 0 0 0
0 00000000 0 0 0
0 00000000 0 1 0
1 00000400 1 0 0
0 00000000 0 0 0
1 00000005 0 0 0
0 00000000 0 0 0
1 fffffff0 0 0 0
0 00000000 0 0 1
1 0000001c 0 0 0
0 00000000 0 0 0
0 00000000 0 0 0
0 00000000 0 0 0
1 00000235 0 0 0
1 0000012a 1 0 0
0 00000000 0 0 0
1 00000010 0 0 0
0 00000000 0 0 0
0 00000000 0 0 0

//--- files.f
verilog/fetchPkg.sv
verilog/cacheLookupIf.sv
verilog/fetchStage.sv
verilog/icacheWay.sv
verilog/wayMerge.sv
verilog/fetchTop.sv
sim/fetchTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the fetch front-end testbench with Verilator and runs it
# A $fatal in the testbench ends the simulation with a nonzero status
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module fetchTb \
    --Mdir obj_dir \
    -o fetchSim \
    -f files.f

./obj_dir/fetchSim
